// ==== canvas_display.f ====
hdl/canvas_pkg.sv
hdl/display_timing.sv
hdl/canvas_layer.sv
hdl/layer_mixer.sv
hdl/canvas_display.sv
bench/canvas_checker.sv
bench/canvas_display_props.sv
bench/canvas_display_tb.sv

// ==== Makefile ====
TOP = canvas_display_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f canvas_display.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f canvas_display.f \
		--top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/canvas_display_tb.sv ====
// ****************************************
// canvas display testbench applying a table
// of writes and probes frame by frame
// ****************************************

`default_nettype none
`timescale 1ns/1ps

module canvas_display_tb import canvas_pkg::*; ();

    localparam int LAYERS = 2;
    localparam int CANV_W = 16;
    localparam int CANV_H = 8;
    localparam int NPR = 4;                    // probes per test
    localparam logic [COLRW-1:0] BG = 15'h0c63;
    localparam int H_SYNC = 4;                 // sync and back porch widths
    localparam int H_BP = 4;
    localparam int V_SYNC = 2;
    localparam int V_BP = 2;

    typedef struct packed {
        logic [127:0] name;
        int           wfirst;                  // first write in wr_q
        int           wcnt;
        int           pfirst;                  // first probe in pr_q
        int           pcnt;
    } row_t;

    typedef struct packed {
        logic signed [CORDW-1:0] x;
        logic signed [CORDW-1:0] y;
        logic [COLRW-1:0]        colr;
        logic                    lit;          // colr is hand computed
    } probe_t;

    logic clk_pix = 1'b0;
    logic rst_sys = 1'b1;
    logic wr_stb = 1'b0;
    wr_cmd_t wr_cmd = '0;
    logic signed [CORDW-1:0] disp_x;
    logic signed [CORDW-1:0] disp_y;
    logic disp_hsync, disp_vsync, disp_de, disp_frame;
    logic [BPC-1:0] disp_r, disp_g, disp_b;

    logic arm = 1'b0;                          // checker handshake
    logic [127:0] tname = '0;
    logic [NPR-1:0] pused = '0;
    logic [NPR-1:0] plit = '0;
    logic [NPR-1:0][CORDW-1:0] px = '0;
    logic [NPR-1:0][CORDW-1:0] py = '0;
    logic [NPR-1:0][COLRW-1:0] pexp = '0;
    logic done;
    int n_tests, n_fail;

    row_t rows[$];
    wr_cmd_t wr_q[$];
    probe_t pr_q[$];
    logic [31:0] rng = 32'h4adf7d7d;

    always #4 clk_pix = ~clk_pix;              // 8 ns pixel clock

    canvas_display #(
        .LAYERS(LAYERS), .CANV_W(CANV_W), .CANV_H(CANV_H), .BG_COLR(BG),
        .H_SYNC(H_SYNC), .H_BP(H_BP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) UUT (
        .clk_pix(clk_pix), .rst_sys(rst_sys), .wr_stb(wr_stb), .wr_cmd(wr_cmd),
        .disp_x(disp_x), .disp_y(disp_y), .disp_hsync(disp_hsync),
        .disp_vsync(disp_vsync), .disp_de(disp_de), .disp_frame(disp_frame),
        .disp_r(disp_r), .disp_g(disp_g), .disp_b(disp_b)
    );

    canvas_checker #(
        .LAYERS(LAYERS), .CANV_W(CANV_W), .CANV_H(CANV_H), .NPR(NPR), .BG_COLR(BG),
        .H_SYNC(H_SYNC), .H_BP(H_BP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) chk (
        .clk_pix(clk_pix), .rst_sys(rst_sys), .wr_stb(wr_stb), .wr_cmd(wr_cmd),
        .disp_x(disp_x), .disp_y(disp_y), .disp_hsync(disp_hsync),
        .disp_vsync(disp_vsync), .disp_de(disp_de), .disp_frame(disp_frame),
        .disp_r(disp_r), .disp_g(disp_g), .disp_b(disp_b),
        .arm(arm), .tname(tname), .pused(pused), .plit(plit), .px(px), .py(py),
        .pexp(pexp), .done(done), .n_tests(n_tests), .n_fail(n_fail)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] win_data(input int x, input int y, input int sh);
        return {6'b0, 2'(sh), 12'(y), 12'(x)};
    endfunction

    task automatic start_row(input logic [127:0] name);
        row_t r;
        r.name = name;
        r.wfirst = wr_q.size();
        r.wcnt = 0;
        r.pfirst = pr_q.size();
        r.pcnt = 0;
        rows.push_back(r);
    endtask

    task automatic add_wr(input wr_op_e op, input int layer, input int addr, input logic [31:0] d);
        wr_cmd_t c;
        c.op = op;
        c.layer = LAYER_IDW'(layer);
        c.addr = 8'(addr);
        c.data = d;
        wr_q.push_back(c);
        rows[rows.size()-1].wcnt += 1;
    endtask

    task automatic add_probe(input int x, input int y, input logic [COLRW-1:0] c, input logic lit);
        probe_t p;
        p.x = CORDW'(x);
        p.y = CORDW'(y);
        p.colr = c;
        p.lit = lit;
        pr_q.push_back(p);
        rows[rows.size()-1].pcnt += 1;
    endtask

    // palette entry i holds grey level i as i*15'h0421
    task automatic build_table();
        start_row("background");
        add_wr(WR_WIN, 0, 0, win_data(100, 100, 0));    // both windows off screen
        add_wr(WR_WIN, 1, 0, win_data(100, 100, 0));
        for (int i = 0; i < 16; i++) add_wr(WR_PAL, 0, i, 32'(i * 15'h0421));
        add_probe(5, 3, BG, 1'b1);
        add_probe(31, 15, BG, 1'b1);
        add_probe(-3, 4, 15'h0, 1'b1);                  // horizontal blanking
        add_probe(-1, 0, 15'h0, 1'b1);
        start_row("addressing");
        add_wr(WR_WIN, 0, 0, win_data(0, 0, 0));
        add_wr(WR_BMAP, 0, 0, 32'h7654_3210);
        add_wr(WR_BMAP, 0, 3, 32'h0000_00a0);           // cy 1, cx 8..15
        add_probe(1, 0, 15'h0421, 1'b1);
        add_probe(5, 0, 15'h14a5, 1'b1);
        add_probe(9, 1, 15'h294a, 1'b1);
        add_probe(8, 1, BG, 1'b1);                      // nibble 0 is transparent
        start_row("window_scale");
        add_wr(WR_WIN, 0, 0, win_data(4, 2, 1));
        add_wr(WR_WIN, 1, 0, win_data(0, 0, 0));
        add_wr(WR_BMAP, 1, 10, 32'h0000_c000);          // cy 5, cx 3
        add_probe(7, 3, 15'h0421, 1'b1);
        add_probe(14, 2, 15'h14a5, 1'b1);
        add_probe(3, 5, 15'h318c, 1'b1);                // left of scaled canvas
        start_row("priority");
        add_wr(WR_WIN, 0, 0, win_data(0, 0, 0));
        add_wr(WR_BMAP, 0, 4, 32'h0000_0f05);
        add_wr(WR_BMAP, 1, 4, 32'h0000_0076);
        add_probe(0, 2, 15'h14a5, 1'b1);
        add_probe(1, 2, 15'h1ce7, 1'b1);                // layer 0 clear, layer 1 shows
        add_probe(2, 2, 15'h3def, 1'b1);
        add_probe(3, 2, BG, 1'b1);
        start_row("palette_update");
        add_wr(WR_PAL, 0, 5, 32'h0000_7c00);
        add_probe(0, 2, 15'h7c00, 1'b1);
        add_probe(5, 0, 15'h7c00, 1'b1);
        add_probe(1, 2, 15'h1ce7, 1'b1);
        for (int r = 0; r < 2; r++) begin
            start_row(r == 0 ? "random_a" : "random_b");
            for (int l = 0; l < LAYERS; l++) begin
                for (int a = 0; a < CANV_W * CANV_H / 8; a++) begin
                    rng = xorshift(rng);
                    add_wr(WR_BMAP, l, a, rng);
                end
                rng = xorshift(rng);
                add_wr(WR_WIN, l, 0, win_data(rng % 16, (rng >> 8) % 8, (rng >> 16) % 2));
            end
            for (int i = 0; i < 16; i++) begin
                rng = xorshift(rng);
                add_wr(WR_PAL, 0, i, {17'b0, rng[14:0]});
            end
            for (int i = 0; i < NPR; i++) begin
                rng = xorshift(rng);
                add_probe(rng % 32, (rng >> 8) % 16, 15'h0, 1'b0);
            end
        end
    endtask

    // writes of one row, then its probes in the frame after next
    task automatic run_row(input int r, output logic hung);
        int t;
        probe_t p;
        hung = 1'b0;
        for (int j = rows[r].wfirst; j < rows[r].wfirst + rows[r].wcnt; j++) begin
            @(posedge clk_pix);
            #1 wr_stb = 1'b1;
            wr_cmd = wr_q[j];
        end
        @(posedge clk_pix);
        #1 wr_stb = 1'b0;
        tname = rows[r].name;
        pused = '0;
        for (int i = 0; i < rows[r].pcnt; i++) begin
            p = pr_q[rows[r].pfirst + i];
            pused[i] = 1'b1;
            plit[i] = p.lit;
            px[i] = p.x;
            py[i] = p.y;
            pexp[i] = p.colr;
        end
        t = 0;
        while (!disp_frame && t < 3000) begin   // let writes settle for a frame
            @(posedge clk_pix);
            #1 t++;
        end
        if (t >= 3000) begin
            $display("timeout while waiting for a frame strobe in %0s", rows[r].name);
            hung = 1'b1;
            return;
        end
        arm = 1'b1;
        @(posedge clk_pix);
        #1 arm = 1'b0;
        t = 0;
        while (!done && t < 4000) begin
            @(posedge clk_pix);
            #1 t++;
        end
        if (t >= 4000) begin
            $display("timeout while waiting for the probed pixels of %0s", rows[r].name);
            hung = 1'b1;
        end
    endtask

    initial begin
        logic hung;
        hung = 1'b0;
        build_table();
        repeat (10) @(posedge clk_pix);
        #1 rst_sys = 1'b0;
        for (int r = 0; r < rows.size() && !hung; r++) begin
            run_row(r, hung);
        end
        $display("%0d tests run, %0d failed, %0d assertion failures",
                 n_tests, n_fail, UUT.props_inst.fail_cnt);
        if (!hung && n_fail == 0 && n_tests == rows.size()
            && UUT.props_inst.fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/canvas_display_props.sv ====
// ****************************************
// display output assertions bound to the top
// ****************************************

`default_nettype none
`timescale 1ns/1ps

module canvas_display_props import canvas_pkg::*; (
    input wire clk_pix,
    input wire rst_sys,
    input wire disp_hsync,
    input wire disp_vsync,
    input wire disp_de,
    input wire disp_frame,
    input wire logic signed [CORDW-1:0] disp_x,
    input wire logic signed [CORDW-1:0] disp_y,
    input wire [BPC-1:0] disp_r,
    input wire [BPC-1:0] disp_g,
    input wire [BPC-1:0] disp_b
);

    int fail_cnt = 0;                          // read by the testbench

    a_blank_black: assert property (@(posedge clk_pix) disable iff (rst_sys)
        !disp_de |-> {disp_r, disp_g, disp_b} == '0)
        else begin
            $error("colour not black while de is low");
            fail_cnt++;
        end

    a_frame_origin: assert property (@(posedge clk_pix) disable iff (rst_sys)
        disp_frame |-> disp_x == 0 && disp_y == 0)
        else begin
            $error("frame strobe away from 0,0");
            fail_cnt++;
        end

    a_frame_pulse: assert property (@(posedge clk_pix) disable iff (rst_sys)
        disp_frame |=> !disp_frame)
        else begin
            $error("frame strobe longer than one cycle");
            fail_cnt++;
        end

    a_reset_idle: assert property (@(posedge clk_pix)
        rst_sys |=> !disp_hsync && !disp_vsync && !disp_de && !disp_frame
                    && {disp_r, disp_g, disp_b} == '0)
        else begin
            $error("outputs not idle after reset");
            fail_cnt++;
        end

endmodule

bind canvas_display canvas_display_props props_inst (.*);

`default_nettype wire

// ==== bench/canvas_checker.sv ====
// ****************************************
// canvas checker that snoops the write port
// and models bitmaps, palette and windows
// ****************************************

`default_nettype none
`timescale 1ns/1ps

module canvas_checker import canvas_pkg::*; #(
    parameter int LAYERS = 2,
    parameter int CANV_W = 16,
    parameter int CANV_H = 8,
    parameter int NPR    = 4,
    parameter logic [COLRW-1:0] BG_COLR = 15'h0c63,
    parameter int H_SYNC = 4,
    parameter int H_BP   = 4,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 2
) (
    input  wire          clk_pix,
    input  wire          rst_sys,
    input  wire          wr_stb,
    input  wire wr_cmd_t wr_cmd,
    input  wire logic signed [CORDW-1:0] disp_x,
    input  wire logic signed [CORDW-1:0] disp_y,
    input  wire          disp_hsync,
    input  wire          disp_vsync,
    input  wire          disp_de,
    input  wire          disp_frame,
    input  wire [BPC-1:0] disp_r,
    input  wire [BPC-1:0] disp_g,
    input  wire [BPC-1:0] disp_b,
    input  wire          arm,          // start of one test
    input  wire [127:0]  tname,
    input  wire [NPR-1:0] pused,
    input  wire [NPR-1:0] plit,
    input  wire [NPR-1:0][CORDW-1:0] px,
    input  wire [NPR-1:0][CORDW-1:0] py,
    input  wire [NPR-1:0][COLRW-1:0] pexp,
    output logic         done = 1'b0,
    output int           n_tests = 0,
    output int           n_fail = 0
);

    localparam int DEPTH = CANV_W * CANV_H / 8;

    logic [WORD-1:0] bmap [LAYERS][DEPTH];     // model memories
    logic [COLRW-1:0] pal [16];
    int win_x [LAYERS];
    int win_y [LAYERS];
    int win_sh [LAYERS];
    logic armed = 1'b0;
    logic in_frame = 1'b0;                     // frame strobe seen
    logic [NPR-1:0] seen = '0;
    int errs = 0;

    // first opaque layer wins and blanking is black
    function automatic logic [COLRW-1:0] model_colr(input int x, input int y);
        int ox, oy, cx, cy;
        logic [CIDXW-1:0] nib;
        if (x < 0 || y < 0) return '0;
        for (int l = 0; l < LAYERS; l++) begin
            ox = x - win_x[l];
            oy = y - win_y[l];
            cx = ox >>> win_sh[l];
            cy = oy >>> win_sh[l];
            if (ox >= 0 && oy >= 0 && cx < CANV_W && cy < CANV_H) begin
                nib = CIDXW'(bmap[l][cy * (CANV_W / 8) + cx / 8] >> (4 * (cx % 8)));
                if (nib != '0) return pal[nib];
            end
        end
        return BG_COLR;
    endfunction

    // syncs sit between front and back porch, de over the visible area
    function automatic logic [2:0] model_ctrl(input int x, input int y);
        logic hs;
        logic vs;
        logic de;
        hs = (x >= -(H_SYNC + H_BP)) && (x < -H_BP);
        vs = (y >= -(V_SYNC + V_BP)) && (y < -V_BP);
        de = (x >= 0) && (y >= 0);
        return {hs, vs, de};
    endfunction

    always @(posedge clk_pix) begin
        logic [COLRW-1:0] want;
        logic [2:0] ctrl;
        if (rst_sys) begin
            for (int l = 0; l < LAYERS; l++) begin
                win_x[l] = 0;
                win_y[l] = 0;
                win_sh[l] = 0;
            end
        end else if (wr_stb) begin
            case (wr_cmd.op)
                WR_BMAP: if (int'(wr_cmd.layer) < LAYERS && int'(wr_cmd.addr) < DEPTH)
                    bmap[wr_cmd.layer][wr_cmd.addr] = wr_cmd.data;
                WR_PAL: pal[wr_cmd.addr[3:0]] = wr_cmd.data[COLRW-1:0];
                WR_WIN: if (int'(wr_cmd.layer) < LAYERS) begin
                    win_x[wr_cmd.layer] = int'(wr_cmd.data[11:0]);
                    win_y[wr_cmd.layer] = int'(wr_cmd.data[23:12]);
                    win_sh[wr_cmd.layer] = int'(wr_cmd.data[25:24]);
                end
                default: ;
            endcase
        end
        if (arm) begin
            armed = 1'b1;
            in_frame = 1'b0;
            seen = '0;
            errs = 0;
            done <= 1'b0;
        end else if (armed) begin
            if (disp_frame) in_frame = 1'b1;
            ctrl = model_ctrl(int'(disp_x), int'(disp_y));
            if (in_frame && {disp_hsync, disp_vsync, disp_de} !== ctrl) begin
                errs++;
                $display("error %0s syncs at %0d,%0d expected %b actual %b", tname,
                         disp_x, disp_y, ctrl, {disp_hsync, disp_vsync, disp_de});
            end
            for (int i = 0; i < NPR; i++) begin
                if (in_frame && pused[i] && !seen[i]
                    && disp_x == px[i] && disp_y == py[i]) begin
                    want = plit[i] ? pexp[i]
                                   : model_colr(int'($signed(px[i])), int'($signed(py[i])));
                    seen[i] = 1'b1;
                    if ({disp_r, disp_g, disp_b} !== want) begin
                        errs++;
                        $display("error %0s at %0d,%0d expected %h actual %h", tname,
                                 $signed(px[i]), $signed(py[i]), want, {disp_r, disp_g, disp_b});
                    end
                end
            end
            if ((seen | ~pused) == '1) begin       // every probe compared
                n_tests++;
                if (errs != 0) n_fail++;
                $display("test %0s %0s", tname, (errs != 0) ? "failed" : "passed");
                armed = 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/canvas_display.sv ====
// ****************************************
// canvas display top: timing, layers, mixer
// ****************************************

`default_nettype none
`timescale 1ns/1ps

module canvas_display import canvas_pkg::*; #(
    parameter int               LAYERS  = 2,
    parameter int               H_RES   = 32,
    parameter int               V_RES   = 16,
    parameter int               H_FP    = 4,
    parameter int               H_SYNC  = 4,
    parameter int               H_BP    = 4,
    parameter int               V_FP    = 2,
    parameter int               V_SYNC  = 2,
    parameter int               V_BP    = 2,
    parameter int               CANV_W  = 16,
    parameter int               CANV_H  = 8,
    parameter logic [COLRW-1:0] BG_COLR = 15'h0c63
) (
    input  wire          clk_pix,
    input  wire          rst_sys,
    input  wire          wr_stb,       // one write per strobe, always taken
    input  wire wr_cmd_t wr_cmd,
    output logic signed [CORDW-1:0] disp_x,
    output logic signed [CORDW-1:0] disp_y,
    output logic         disp_hsync,
    output logic         disp_vsync,
    output logic         disp_de,
    output logic         disp_frame,
    output logic [BPC-1:0] disp_r,
    output logic [BPC-1:0] disp_g,
    output logic [BPC-1:0] disp_b
);

    disp_timing_t              tim;                 // from generator
    disp_timing_t              tim_lyr [LAYERS];    // per layer delay, 0 used
    layer_pix_t [LAYERS-1:0]   lpix;

    display_timing #(
        .H_RES(H_RES), .V_RES(V_RES),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) timing_inst (
        .clk_pix(clk_pix),
        .rst_sys(rst_sys),
        .tim(tim)
    );

    for (genvar i = 0; i < LAYERS; i++) begin : g_layer
        canvas_layer #(
            .LAYER_NUM(i),
            .CANV_W(CANV_W),
            .CANV_H(CANV_H)
        ) layer_inst (
            .clk_pix(clk_pix),
            .rst_sys(rst_sys),
            .wr_stb(wr_stb),
            .wr_cmd(wr_cmd),
            .tim(tim),
            .tim_d(tim_lyr[i]),
            .lpix(lpix[i])
        );
    end

    layer_mixer #(
        .LAYERS(LAYERS),
        .BG_COLR(BG_COLR)
    ) mixer_inst (
        .clk_pix(clk_pix),
        .rst_sys(rst_sys),
        .wr_stb(wr_stb),
        .wr_cmd(wr_cmd),
        .tim_d(tim_lyr[0]),            // 3 cycle delayed timing
        .lpix(lpix),
        .disp_x(disp_x),
        .disp_y(disp_y),
        .disp_hsync(disp_hsync),
        .disp_vsync(disp_vsync),
        .disp_de(disp_de),
        .disp_frame(disp_frame),
        .disp_r(disp_r),
        .disp_g(disp_g),
        .disp_b(disp_b)
    );

endmodule

`default_nettype wire

// ==== hdl/layer_mixer.sv ====
// ****************************************
// layer mixer: priority, palette lookup
// and registered display outputs
// ****************************************

`default_nettype none
`timescale 1ns/1ps

module layer_mixer import canvas_pkg::*; #(
    parameter int               LAYERS  = 2,
    parameter logic [COLRW-1:0] BG_COLR = 15'h0c63  // shown where no layer paints
) (
    input  wire          clk_pix,
    input  wire          rst_sys,
    input  wire          wr_stb,
    input  wire wr_cmd_t wr_cmd,
    input  wire disp_timing_t tim_d,   // timing aligned with lpix
    input  wire layer_pix_t [LAYERS-1:0] lpix,
    output logic signed [CORDW-1:0] disp_x,
    output logic signed [CORDW-1:0] disp_y,
    output logic         disp_hsync,
    output logic         disp_vsync,
    output logic         disp_de,
    output logic         disp_frame,
    output logic [BPC-1:0] disp_r,
    output logic [BPC-1:0] disp_g,
    output logic [BPC-1:0] disp_b
);

    logic [COLRW-1:0] pal [2**CIDXW];  // RGB555 palette

    logic             hit;             // some layer is opaque here
    logic [CIDXW-1:0] sel_idx;
    logic [COLRW-1:0] pal_q;
    logic             hit_q;
    disp_timing_t     tim_q;
    logic [COLRW-1:0] colr;

    always_ff @(posedge clk_pix) begin
        if (wr_stb && wr_cmd.op == WR_PAL) begin
            pal[wr_cmd.addr[CIDXW-1:0]] <= wr_cmd.data[COLRW-1:0];
        end
    end

    // lowest numbered opaque layer wins
    always_comb begin
        hit = 1'b0;
        sel_idx = '0;
        for (int i = LAYERS - 1; i >= 0; i--) begin
            if (lpix[i].paint && lpix[i].cidx != '0) begin
                hit = 1'b1;
                sel_idx = lpix[i].cidx;
            end
        end
    end

    // stage A: palette read
    always_ff @(posedge clk_pix) begin
        pal_q <= pal[sel_idx];
        if (rst_sys) begin
            hit_q <= 1'b0;
            tim_q <= '0;
        end else begin
            hit_q <= hit;
            tim_q <= tim_d;
        end
    end

    assign colr = hit_q ? pal_q : BG_COLR;

    // stage B: all outputs in one register
    always_ff @(posedge clk_pix) begin
        if (rst_sys) begin
            disp_x <= '0;
            disp_y <= '0;
            disp_hsync <= 1'b0;
            disp_vsync <= 1'b0;
            disp_de <= 1'b0;
            disp_frame <= 1'b0;
            {disp_r, disp_g, disp_b} <= '0;
        end else begin
            disp_x <= tim_q.x;
            disp_y <= tim_q.y;
            disp_hsync <= tim_q.hsync;
            disp_vsync <= tim_q.vsync;
            disp_de <= tim_q.de;
            disp_frame <= tim_q.frame;
            {disp_r, disp_g, disp_b} <= tim_q.de ? colr : '0;  // black in blanking
        end
    end

endmodule

`default_nettype wire

// ==== hdl/canvas_layer.sv ====
// ****************************************
// canvas layer: windowed, scalable 4bpp
// bitmap turning coordinates into cidx
// ****************************************

`default_nettype none
`timescale 1ns/1ps

module canvas_layer import canvas_pkg::*; #(
    parameter int LAYER_NUM = 0,       // matched against wr_cmd.layer
    parameter int CANV_W    = 16,      // canvas width, multiple of 8
    parameter int CANV_H    = 8        // canvas height in lines
) (
    input  wire          clk_pix,
    input  wire          rst_sys,
    input  wire          wr_stb,
    input  wire wr_cmd_t wr_cmd,
    input  wire disp_timing_t tim,
    output disp_timing_t tim_d,        // tim delayed to match lpix
    output layer_pix_t   lpix
);

    localparam int WPL   = CANV_W / 8;           // words per line
    localparam int DEPTH = CANV_W * CANV_H / 8;  // bitmap words
    localparam int ADDRW = $clog2(DEPTH);
    localparam int PIDW  = 3;                     // pixel within word

    logic            sel;              // write targets this layer
    logic [11:0]     win_x;            // window start x
    logic [11:0]     win_y;            // window start y
    logic [1:0]      win_sh;           // scale shift

    logic [WORD-1:0] bmap [DEPTH];     // bitmap memory

    logic signed [CORDW-1:0] off_x;    // offset from window start
    logic signed [CORDW-1:0] off_y;
    logic signed [CORDW-1:0] cx;       // canvas coordinates
    logic signed [CORDW-1:0] cy;
    logic                    in_win;
    logic [ADDRW-1:0]        addr_c;

    logic [ADDRW-1:0] addr_q;          // stage 1
    logic [PIDW-1:0]  pid_q;
    logic             paint_q;
    logic [WORD-1:0]  word_q;          // stage 2
    logic [PIDW-1:0]  pid_q2;
    logic             paint_q2;
    disp_timing_t     tim_q1;          // timing delay line
    disp_timing_t     tim_q2;

    assign sel = wr_stb && (wr_cmd.layer == LAYER_IDW'(LAYER_NUM));

    // window registers
    always_ff @(posedge clk_pix) begin
        if (rst_sys) begin
            win_x <= '0;
            win_y <= '0;
            win_sh <= '0;
        end else if (sel && wr_cmd.op == WR_WIN) begin
            win_x <= wr_cmd.data[11:0];
            win_y <= wr_cmd.data[23:12];
            win_sh <= wr_cmd.data[25:24];
        end
    end

    // bitmap write, out of range addresses dropped
    always_ff @(posedge clk_pix) begin
        if (sel && wr_cmd.op == WR_BMAP && int'(wr_cmd.addr) < DEPTH) begin
            bmap[wr_cmd.addr[ADDRW-1:0]] <= wr_cmd.data;
        end
    end

    // canvas coords and word address
    always_comb begin
        off_x = tim.x - CORDW'(win_x);
        off_y = tim.y - CORDW'(win_y);
        cx = off_x >>> win_sh;         // each canvas pixel covers 2^sh
        cy = off_y >>> win_sh;
        in_win = (off_x >= 0) && (off_y >= 0) && (cx < CANV_W) && (cy < CANV_H);
        if (in_win) begin
            addr_c = ADDRW'(cy * WPL + (cx >>> 3));
        end else begin
            addr_c = '0;               // keep reads in range
        end
    end

    // stage 1: address and flag, stage 2: ram read
    always_ff @(posedge clk_pix) begin
        addr_q <= addr_c;
        pid_q <= cx[PIDW-1:0];         // cx mod 8
        word_q <= bmap[addr_q];
        pid_q2 <= pid_q;
    end

    // control side of the pipe, cleared by reset
    always_ff @(posedge clk_pix) begin
        if (rst_sys) begin
            paint_q <= 1'b0;
            paint_q2 <= 1'b0;
            lpix <= '0;
            tim_q1 <= '0;
            tim_q2 <= '0;
            tim_d <= '0;
        end else begin
            paint_q <= in_win;
            paint_q2 <= paint_q;
            lpix.paint <= paint_q2;                           // stage 3
            lpix.cidx <= word_q[{pid_q2, 2'b00} +: CIDXW];   // lsb nibble first
            tim_q1 <= tim;
            tim_q2 <= tim_q1;
            tim_d <= tim_q2;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/display_timing.sv ====
// ****************************************
// display timing generator
// coordinates, syncs, de and frame strobe
// ****************************************

`default_nettype none
`timescale 1ns/1ps

module display_timing import canvas_pkg::*; #(
    parameter int H_RES  = 32,         // visible pixels
    parameter int V_RES  = 16,         // visible lines
    parameter int H_FP   = 4,          // horizontal front porch
    parameter int H_SYNC = 4,
    parameter int H_BP   = 4,
    parameter int V_FP   = 2,          // vertical front porch
    parameter int V_SYNC = 2,
    parameter int V_BP   = 2
) (
    input  wire          clk_pix,
    input  wire          rst_sys,
    output disp_timing_t tim
);

    // blanking runs negative so active video starts at 0
    localparam logic signed [CORDW-1:0] H_STA  = CORDW'(0 - H_FP - H_SYNC - H_BP);
    localparam logic signed [CORDW-1:0] HS_STA = CORDW'(0 - H_SYNC - H_BP);
    localparam logic signed [CORDW-1:0] HS_END = CORDW'(0 - H_BP);
    localparam logic signed [CORDW-1:0] HA_END = CORDW'(H_RES - 1);
    localparam logic signed [CORDW-1:0] V_STA  = CORDW'(0 - V_FP - V_SYNC - V_BP);
    localparam logic signed [CORDW-1:0] VS_STA = CORDW'(0 - V_SYNC - V_BP);
    localparam logic signed [CORDW-1:0] VS_END = CORDW'(0 - V_BP);
    localparam logic signed [CORDW-1:0] VA_END = CORDW'(V_RES - 1);

    logic signed [CORDW-1:0] x;        // horizontal counter
    logic signed [CORDW-1:0] y;        // vertical counter

    always_ff @(posedge clk_pix) begin
        if (rst_sys) begin
            x <= H_STA;                // front porch of last line
            y <= VA_END;
        end else if (x == HA_END) begin
            x <= H_STA;                // wrap to next line
            if (y == VA_END) begin
                y <= V_STA;
            end else begin
                y <= y + CORDW'(1);
            end
        end else begin
            x <= x + CORDW'(1);
        end
    end

    // decode straight from the counters
    always_comb begin
        tim.x = x;
        tim.y = y;
        tim.hsync = (x >= HS_STA) && (x < HS_END);  // positive sync
        tim.vsync = (y >= VS_STA) && (y < VS_END);
        tim.de = (x >= 0) && (y >= 0);
        tim.frame = (x == 0) && (y == 0);
        tim.line = (x == H_STA);                     // start incl blanking
    end

endmodule

`default_nettype wire

// ==== hdl/canvas_pkg.sv ====
// ****************************************
// canvas display shared definitions
// widths, write command and pipeline structs
// ****************************************

`default_nettype none

package canvas_pkg;

    localparam int CORDW = 16;         // signed coordinate width
    localparam int BPC = 5;            // bits per colour channel
    localparam int COLRW = 3 * BPC;    // RGB555 colour
    localparam int WORD = 32;          // bitmap word, 8 pixels of 4 bits
    localparam int CIDXW = 4;          // colour index, 0 is transparent
    localparam int LAYER_IDW = 2;      // up to 4 layers

    // host write opcodes
    typedef enum logic [1:0] {
        WR_NOP  = 2'd0,
        WR_BMAP = 2'd1,                // one bitmap word of a layer
        WR_PAL  = 2'd2,                // one palette entry
        WR_WIN  = 2'd3                 // window start x/y and scale shift
    } wr_op_e;

    // one host write, data[11:0] x, [23:12] y, [25:24] shift for WR_WIN
    typedef struct packed {
        wr_op_e                 op;
        logic [LAYER_IDW-1:0]   layer;
        logic [7:0]             addr;
        logic [WORD-1:0]        data;
    } wr_cmd_t;

    // one pixel slot of display timing
    typedef struct packed {
        logic signed [CORDW-1:0] x;    // negative in leading blanking
        logic signed [CORDW-1:0] y;
        logic                    hsync;
        logic                    vsync;
        logic                    de;
        logic                    frame; // first cycle of frame, at 0,0
        logic                    line;  // first cycle of each line
    } disp_timing_t;

    // one layer's contribution to a pixel
    typedef struct packed {
        logic              paint;      // inside window and canvas
        logic [CIDXW-1:0]  cidx;
    } layer_pix_t;

endpackage

`default_nettype wire
